// File: include/mci_settings.svh
// Management controller sizes
`ifndef MCI_SETTINGS_SVH
`define MCI_SETTINGS_SVH

// Bus request address width
`define MCI_ADDR_W 16

// Data width of bus and SRAM
`define MCI_DATA_W 32

// Requester user ID width
`define MCI_USER_W 8

// SRAM depth in words
`define MCI_SRAM_WORDS 1024

// SRAM region starts here, registers sit below
`define MCI_SRAM_BASE 16'h8000

// Watchdog period in 32-bit words
`define MCI_WDT_DWORDS 2
`define MCI_WDT_PERIOD_W (`MCI_WDT_DWORDS * 32)

`endif

// File: verilog/mci_pkg.sv
// Management controller types
`include "mci_settings.svh"

package mci_pkg;

    localparam int SRAM_AW   = $clog2(`MCI_SRAM_WORDS);
    localparam int REG_IDX_W = 4;

    // Address seen as an SRAM word
    typedef struct packed {
        logic                               region;
        logic [`MCI_ADDR_W-SRAM_AW-4:0]     rsvd;
        logic [SRAM_AW-1:0]                 word;
        logic [1:0]                         byte_off;
    } mci_sram_addr_t;

    // Address seen as a register
    typedef struct packed {
        logic                               region;
        logic [`MCI_ADDR_W-REG_IDX_W-4:0]   rsvd;
        logic [REG_IDX_W-1:0]               idx;
        logic [1:0]                         byte_off;
    } mci_reg_addr_t;

    // Region bit sits at the top in both views
    typedef union packed {
        mci_sram_addr_t sram;
        mci_reg_addr_t  regs;
    } mci_addr_u;

    typedef struct packed {
        logic                       write;
        mci_addr_u                  addr;
        logic [`MCI_DATA_W-1:0]     wdata;
        logic [`MCI_USER_W-1:0]     user;
    } mci_req_t;

    typedef struct packed {
        logic [`MCI_DATA_W-1:0]     rdata;
        logic                       err;
    } mci_resp_t;

    // External SRAM port
    typedef struct packed {
        logic                       cs;
        logic                       we;
        logic [SRAM_AW-1:0]         addr;
        logic [`MCI_DATA_W-1:0]     wdata;
    } mci_sram_req_t;

    typedef struct packed {
        logic                               timer1_en;
        logic                               timer2_en;
        logic                               timer1_restart;
        logic                               timer2_restart;
        logic [`MCI_WDT_DWORDS-1:0][31:0]   timer1_period;
        logic [`MCI_WDT_DWORDS-1:0][31:0]   timer2_period;
    } mci_wdt_ctrl_t;

    typedef enum logic [REG_IDX_W-1:0] {
        T1_EN,
        T1_CTRL,
        T1_PERIOD0,
        T1_PERIOD1,
        T2_EN,
        T2_CTRL,
        T2_PERIOD0,
        T2_PERIOD1,
        WDT_STATUS,
        EXEC_SIZE
    } mci_reg_idx_e;

endpackage

// File: verilog/mci_bus_sub.sv
// Bus subordinate and target router

module mci_bus_sub (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  mci_pkg::mci_req_t   req,
    input  logic                reg_resp_valid,
    input  mci_pkg::mci_resp_t  reg_resp,
    input  logic                sram_resp_valid,
    input  mci_pkg::mci_resp_t  sram_resp,
    output logic                req_ready,
    output logic                resp_valid,
    output mci_pkg::mci_resp_t  resp,
    output logic                reg_valid,
    output logic                sram_valid,
    output mci_pkg::mci_req_t   fwd_req
);

    logic busy;
    logic tgt_sram;
    logic accept;

    // One request in flight at a time
    assign req_ready = !busy;
    assign accept    = req_valid && req_ready;

    // Strobes and busy flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            reg_valid  <= 1'b0;
            sram_valid <= 1'b0;
        end else begin
            // Region bit picks the target
            reg_valid  <= accept && !req.addr.sram.region;
            sram_valid <= accept && req.addr.sram.region;
            if (accept) begin
                busy <= 1'b1;
            end else if (resp_valid) begin
                busy <= 1'b0;
            end
        end
    end

    // Request payload, held until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            fwd_req  <= req;
            tgt_sram <= req.addr.sram.region;
        end
    end

    // Only the addressed target may answer
    assign resp_valid = busy && (tgt_sram ? sram_resp_valid : reg_resp_valid);
    assign resp       = tgt_sram ? sram_resp : reg_resp;

endmodule

// File: verilog/mci_sram_ctrl.sv
// SRAM access control
// Region permissions by user ID, fixed read latency
`include "mci_settings.svh"

module mci_sram_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sram_valid,
    input  mci_pkg::mci_req_t           fwd_req,
    input  logic [`MCI_DATA_W-1:0]      exec_size,
    input  logic                        exec_region_lock,
    input  logic [`MCI_USER_W-1:0]      strap_mcu_lsu_user,
    input  logic [`MCI_USER_W-1:0]      strap_mcu_ifu_user,
    input  logic [`MCI_USER_W-1:0]      strap_clp_user,
    input  logic [`MCI_DATA_W-1:0]      sram_rdata,
    output logic                        sram_resp_valid,
    output mci_pkg::mci_resp_t          sram_resp,
    output mci_pkg::mci_sram_req_t      sram_req
);

    logic                           is_mcu;
    logic                           is_clp;
    logic                           in_exec;
    logic                           allowed;
    logic                           sram_cs;
    logic                           sram_we;
    logic [mci_pkg::SRAM_AW-1:0]    sram_addr;
    logic [`MCI_DATA_W-1:0]         sram_wdata;
    logic                           rd_pend;
    logic                           imm_resp;
    logic                           imm_err;

    // Requester class from straps
    assign is_mcu = (fwd_req.user == strap_mcu_lsu_user) ||
                    (fwd_req.user == strap_mcu_ifu_user);
    assign is_clp = fwd_req.user == strap_clp_user;

    // Execution region covers words below exec_size
    assign in_exec = (`MCI_DATA_W)'(fwd_req.addr.sram.word) < exec_size;

    // Lock hands the execution region from CLP to MCU
    always_comb begin
        if (in_exec) begin
            allowed = exec_region_lock ? is_mcu : is_clp;
        end else begin
            allowed = is_mcu || is_clp;
        end
    end

    // Port enable and response sequencing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sram_cs  <= 1'b0;
            sram_we  <= 1'b0;
            rd_pend  <= 1'b0;
            imm_resp <= 1'b0;
        end else begin
            sram_cs  <= sram_valid && allowed;
            sram_we  <= sram_valid && allowed && fwd_req.write;
            // Read data comes back one cycle after the enable
            rd_pend  <= sram_cs && !sram_we;
            // Writes and denials answer right away
            imm_resp <= sram_valid && !(allowed && !fwd_req.write);
        end
    end

    // Port payload
    always_ff @(posedge clk) begin
        if (sram_valid) begin
            sram_addr  <= fwd_req.addr.sram.word;
            sram_wdata <= fwd_req.wdata;
            imm_err    <= !allowed;
        end
    end

    assign sram_req = '{
        cs:    sram_cs,
        we:    sram_we,
        addr:  sram_addr,
        wdata: sram_wdata
    };

    assign sram_resp_valid = rd_pend || imm_resp;
    // Denied or write responses carry zero data
    assign sram_resp.rdata = rd_pend ? sram_rdata : '0;
    assign sram_resp.err   = imm_resp && imm_err;

endmodule

// File: verilog/mci_reg_bank.sv
// Watchdog and SRAM control registers
`include "mci_settings.svh"

module mci_reg_bank (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        reg_valid,
    input  mci_pkg::mci_req_t           fwd_req,
    input  logic                        t1_timeout_p,
    input  logic                        t2_timeout_p,
    output logic                        reg_resp_valid,
    output mci_pkg::mci_resp_t          reg_resp,
    output mci_pkg::mci_wdt_ctrl_t      wdt_ctrl,
    output logic [`MCI_DATA_W-1:0]      exec_size,
    output logic [1:0]                  wdt_status
);

    mci_pkg::mci_reg_idx_e      idx;
    logic                       wr;
    logic [`MCI_DATA_W-1:0]     wdata;
    logic [`MCI_DATA_W-1:0]     rdata;
    logic                       hit;
    logic                       status_wr;

    assign idx       = mci_pkg::mci_reg_idx_e'(fwd_req.addr.regs.idx);
    assign wr        = reg_valid && fwd_req.write;
    assign wdata     = fwd_req.wdata;
    assign status_wr = wr && (idx == mci_pkg::WDT_STATUS);

    // Read mux
    always_comb begin
        rdata = '0;
        hit   = 1'b1;
        case (idx)
            mci_pkg::T1_EN:      rdata[0]   = wdt_ctrl.timer1_en;
            mci_pkg::T1_CTRL:    rdata[0]   = wdt_ctrl.timer1_restart;
            mci_pkg::T1_PERIOD0: rdata      = wdt_ctrl.timer1_period[0];
            mci_pkg::T1_PERIOD1: rdata      = wdt_ctrl.timer1_period[1];
            mci_pkg::T2_EN:      rdata[0]   = wdt_ctrl.timer2_en;
            mci_pkg::T2_CTRL:    rdata[0]   = wdt_ctrl.timer2_restart;
            mci_pkg::T2_PERIOD0: rdata      = wdt_ctrl.timer2_period[0];
            mci_pkg::T2_PERIOD1: rdata      = wdt_ctrl.timer2_period[1];
            mci_pkg::WDT_STATUS: rdata[1:0] = wdt_status;
            mci_pkg::EXEC_SIZE:  rdata      = exec_size;
            // Unmapped index
            default:             hit        = 1'b0;
        endcase
    end

    // Register writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wdt_ctrl       <= '0;
            exec_size      <= '0;
            wdt_status     <= '0;
            reg_resp_valid <= 1'b0;
        end else begin
            reg_resp_valid <= reg_valid;
            // Restart bits last a single cycle
            wdt_ctrl.timer1_restart <= wr && (idx == mci_pkg::T1_CTRL) && wdata[0];
            wdt_ctrl.timer2_restart <= wr && (idx == mci_pkg::T2_CTRL) && wdata[0];
            if (wr) begin
                case (idx)
                    mci_pkg::T1_EN:      wdt_ctrl.timer1_en        <= wdata[0];
                    mci_pkg::T1_PERIOD0: wdt_ctrl.timer1_period[0] <= wdata;
                    mci_pkg::T1_PERIOD1: wdt_ctrl.timer1_period[1] <= wdata;
                    mci_pkg::T2_EN:      wdt_ctrl.timer2_en        <= wdata[0];
                    mci_pkg::T2_PERIOD0: wdt_ctrl.timer2_period[0] <= wdata;
                    mci_pkg::T2_PERIOD1: wdt_ctrl.timer2_period[1] <= wdata;
                    mci_pkg::EXEC_SIZE:  exec_size                 <= wdata;
                    default: ;
                endcase
            end
            // Write one to clear, a new timeout wins
            wdt_status[0] <= t1_timeout_p || (wdt_status[0] && !(status_wr && wdata[0]));
            wdt_status[1] <= t2_timeout_p || (wdt_status[1] && !(status_wr && wdata[1]));
        end
    end

    // Response payload
    always_ff @(posedge clk) begin
        if (reg_valid) begin
            reg_resp.rdata <= (hit && !fwd_req.write) ? rdata : '0;
            reg_resp.err   <= !hit;
        end
    end

endmodule

// File: verilog/mci_wdt.sv
// Two-timer watchdog with cascade
`include "mci_settings.svh"

module mci_wdt (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mci_pkg::mci_wdt_ctrl_t  wdt_ctrl,
    output logic                    t1_timeout_p,
    output logic                    t2_timeout_p
);

    logic [1:0]                         run;
    logic [1:0]                         restart;
    logic [1:0]                         done;
    logic [1:0]                         hit;
    logic [1:0][`MCI_WDT_PERIOD_W-1:0]  period;

    assign period  = {wdt_ctrl.timer2_period, wdt_ctrl.timer1_period};
    assign restart = {wdt_ctrl.timer2_restart, wdt_ctrl.timer1_restart};

    // Timer 2 also runs in cascade once timer 1 has expired
    assign run[0] = wdt_ctrl.timer1_en;
    assign run[1] = wdt_ctrl.timer2_en || (!wdt_ctrl.timer2_en && done[0]);

    for (genvar i = 0; i < 2; i++) begin : g_timer
        logic [`MCI_WDT_PERIOD_W-1:0]   count;
        logic                           expired;

        // Single pulse when the count reaches the period
        assign hit[i]  = run[i] && !expired && (count == period[i]);
        assign done[i] = expired;

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                count   <= '0;
                expired <= 1'b0;
            end else if (restart[i] || !run[i]) begin
                count   <= '0;
                expired <= 1'b0;
            end else if (hit[i]) begin
                // Hold here until restarted
                expired <= 1'b1;
            end else if (!expired) begin
                count <= count + 1'b1;
            end
        end
    end

    assign t1_timeout_p = hit[0];
    assign t2_timeout_p = hit[1];

endmodule

// File: verilog/mci_top.sv
// Management controller top level
`include "mci_settings.svh"

module mci_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid,
    input  mci_pkg::mci_req_t           req,
    input  logic [`MCI_USER_W-1:0]      strap_mcu_lsu_user,
    input  logic [`MCI_USER_W-1:0]      strap_mcu_ifu_user,
    input  logic [`MCI_USER_W-1:0]      strap_clp_user,
    input  logic                        exec_region_lock,
    input  logic [`MCI_DATA_W-1:0]      sram_rdata,
    output logic                        req_ready,
    output logic                        resp_valid,
    output mci_pkg::mci_resp_t          resp,
    output mci_pkg::mci_sram_req_t      sram_req,
    output logic                        wdt_t1_timeout,
    output logic                        wdt_t2_timeout
);

    // Routed request
    logic                       reg_valid;
    logic                       sram_valid;
    mci_pkg::mci_req_t          fwd_req;

    // Target responses
    logic                       reg_resp_valid;
    mci_pkg::mci_resp_t         reg_resp;
    logic                       sram_resp_valid;
    mci_pkg::mci_resp_t         sram_resp;

    // Control from the register bank
    mci_pkg::mci_wdt_ctrl_t     wdt_ctrl;
    logic [`MCI_DATA_W-1:0]     exec_size;
    logic                       t1_timeout_p;
    logic                       t2_timeout_p;

    mci_bus_sub mci_bus_sub_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_valid       (req_valid),
        .req             (req),
        .reg_resp_valid  (reg_resp_valid),
        .reg_resp        (reg_resp),
        .sram_resp_valid (sram_resp_valid),
        .sram_resp       (sram_resp),
        .req_ready       (req_ready),
        .resp_valid      (resp_valid),
        .resp            (resp),
        .reg_valid       (reg_valid),
        .sram_valid      (sram_valid),
        .fwd_req         (fwd_req)
    );

    // Status bits double as the timeout levels
    mci_reg_bank mci_reg_bank_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .reg_valid      (reg_valid),
        .fwd_req        (fwd_req),
        .t1_timeout_p   (t1_timeout_p),
        .t2_timeout_p   (t2_timeout_p),
        .reg_resp_valid (reg_resp_valid),
        .reg_resp       (reg_resp),
        .wdt_ctrl       (wdt_ctrl),
        .exec_size      (exec_size),
        .wdt_status     ({wdt_t2_timeout, wdt_t1_timeout})
    );

    mci_sram_ctrl mci_sram_ctrl_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .sram_valid         (sram_valid),
        .fwd_req            (fwd_req),
        .exec_size          (exec_size),
        .exec_region_lock   (exec_region_lock),
        .strap_mcu_lsu_user (strap_mcu_lsu_user),
        .strap_mcu_ifu_user (strap_mcu_ifu_user),
        .strap_clp_user     (strap_clp_user),
        .sram_rdata         (sram_rdata),
        .sram_resp_valid    (sram_resp_valid),
        .sram_resp          (sram_resp),
        .sram_req           (sram_req)
    );

    mci_wdt mci_wdt_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .wdt_ctrl     (wdt_ctrl),
        .t1_timeout_p (t1_timeout_p),
        .t2_timeout_p (t2_timeout_p)
    );

endmodule

// File: tb/tb_mci_top.sv
// Management controller testbench
`include "mci_settings.svh"

module tb_mci_top;
    timeunit 1ns;
    timeprecision 1ps;

    // Cycle budgets of the tests summed for the watchdog
    localparam int CYC_REGS    = 200;
    localparam int CYC_SRAM    = 200;
    localparam int CYC_PERM    = 200;
    localparam int CYC_WDT     = 300;
    localparam int CYC_CASCADE = 400;
    localparam int CYC_BACK    = 200;
    localparam int CYC_TOTAL   = CYC_REGS + CYC_SRAM + CYC_PERM + CYC_WDT + CYC_CASCADE
                                 + CYC_BACK;
    localparam int RESP_LIMIT  = 50;

    localparam logic [7:0] LSU_USER = 8'h11;
    localparam logic [7:0] IFU_USER = 8'h12;
    localparam logic [7:0] CLP_USER = 8'h20;
    localparam logic [7:0] BAD_USER = 8'h7f;

    logic                       clk;
    logic                       rst_n;
    logic                       req_valid;
    mci_pkg::mci_req_t          req;
    logic                       exec_region_lock;
    logic [`MCI_DATA_W-1:0]     sram_rdata;
    logic                       req_ready;
    logic                       resp_valid;
    mci_pkg::mci_resp_t         resp;
    mci_pkg::mci_sram_req_t     sram_req;
    logic                       wdt_t1_timeout;
    logic                       wdt_t2_timeout;

    // SRAM model state
    logic [31:0]    sram_mem [0:`MCI_SRAM_WORDS-1];
    int             sram_en_cnt;

    int             seed;
    int             errors;
    int             tests_run;
    int             tests_failed;
    int             test_err_base;

    mci_top mci_top_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .req_valid          (req_valid),
        .req                (req),
        .strap_mcu_lsu_user (LSU_USER),
        .strap_mcu_ifu_user (IFU_USER),
        .strap_clp_user     (CLP_USER),
        .exec_region_lock   (exec_region_lock),
        .sram_rdata         (sram_rdata),
        .req_ready          (req_ready),
        .resp_valid         (resp_valid),
        .resp               (resp),
        .sram_req           (sram_req),
        .wdt_t1_timeout     (wdt_t1_timeout),
        .wdt_t2_timeout     (wdt_t2_timeout)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // One cycle read latency with updates on the falling edge
    always @(negedge clk) begin
        if (sram_req.cs) begin
            sram_en_cnt = sram_en_cnt + 1;
            if (sram_req.we) begin
                sram_mem[sram_req.addr] <= sram_req.wdata;
            end else begin
                sram_rdata <= sram_mem[sram_req.addr];
            end
        end
    end

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("error at %0d ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic start_test();
        test_err_base = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_err_base) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - test_err_base);
        end
    endtask

    // Single request that returns the response; exp_lat of zero skips the latency check
    task automatic do_req(input logic w, input logic [15:0] a, input logic [31:0] d,
                          input logic [7:0] u, input int exp_lat,
                          output mci_pkg::mci_resp_t r);
        int lat;
        int wait_cyc;
        lat = 0;
        wait_cyc = 0;
        r = '0;
        @(negedge clk);
        req.write = w;
        req.addr  = a;
        req.wdata = d;
        req.user  = u;
        req_valid = 1'b1;
        while (!req_ready && wait_cyc < RESP_LIMIT) begin
            @(negedge clk);
            wait_cyc++;
        end
        if (!req_ready) begin
            $display("request at address %h was never accepted", a);
            errors++;
            req_valid = 1'b0;
            return;
        end
        // Accepted on the coming rising edge
        @(negedge clk);
        req_valid = 1'b0;
        lat = 1;
        while (!resp_valid && lat < RESP_LIMIT) begin
            @(negedge clk);
            lat++;
        end
        if (!resp_valid) begin
            $display("request at address %h got no response", a);
            errors++;
            return;
        end
        r = resp;
        if (exp_lat > 0) begin
            check_eq(lat, exp_lat, "response latency");
        end
    endtask

    task automatic reg_write(input int idx, input logic [31:0] d);
        mci_pkg::mci_resp_t r;
        do_req(1'b1, 16'(idx << 2), d, CLP_USER, 2, r);
        check_eq(r.err, 1'b0, "register write error flag");
    endtask

    task automatic reg_read(input int idx, output logic [31:0] d);
        mci_pkg::mci_resp_t r;
        do_req(1'b0, 16'(idx << 2), '0, CLP_USER, 2, r);
        check_eq(r.err, 1'b0, "register read error flag");
        d = r.rdata;
    endtask

    function automatic logic [15:0] sram_addr(input int word);
        return `MCI_SRAM_BASE | 16'(word << 2);
    endfunction

    task automatic register_access();
        logic [31:0] vals [10];
        logic [31:0] rd;
        int idx_list [7];
        mci_pkg::mci_resp_t r;
        idx_list = '{2, 3, 6, 7, 9, 0, 4};
        start_test();
        foreach (idx_list[i]) begin
            vals[i] = $random(seed);
            // Enables hold a single bit
            if (idx_list[i] == 0 || idx_list[i] == 4) begin
                vals[i] = vals[i] & 32'h1;
            end
            reg_write(idx_list[i], vals[i]);
        end
        foreach (idx_list[i]) begin
            reg_read(idx_list[i], rd);
            check_eq(rd, vals[i], $sformatf("register %0d readback", idx_list[i]));
        end
        do_req(1'b0, 16'(12 << 2), '0, CLP_USER, 2, r);
        check_eq(r.err, 1'b1, "unknown register error flag");
        check_eq(r.rdata, '0, "unknown register data");
        reg_write(0, 0);
        reg_write(4, 0);
        end_test("registers");
    endtask

    task automatic sram_user_access();
        logic [7:0] users [3];
        int words [3];
        logic [31:0] data [3];
        mci_pkg::mci_resp_t r;
        users = '{LSU_USER, IFU_USER, CLP_USER};
        start_test();
        reg_write(9, 256);
        foreach (users[i]) begin
            words[i] = 256 + i * 200 + ($unsigned($random(seed)) % 150);
            data[i]  = $random(seed);
            do_req(1'b1, sram_addr(words[i]), data[i], users[i], 2, r);
            check_eq(r.err, 1'b0, "SRAM write error flag");
        end
        foreach (users[i]) begin
            do_req(1'b0, sram_addr(words[i]), '0, users[i], 3, r);
            check_eq(r.err, 1'b0, "SRAM read error flag");
            check_eq(r.rdata, data[i], "SRAM read data");
            check_eq(sram_mem[words[i]], data[i], "SRAM model contents");
        end
        end_test("sram");
    endtask

    // Access to one SRAM word with result and enable checks
    task automatic perm_access(input logic [7:0] u, input int word, input logic ok,
                               input logic [31:0] d);
        mci_pkg::mci_resp_t r;
        int en_before;
        en_before = sram_en_cnt;
        do_req(1'b1, sram_addr(word), d, u, 2, r);
        check_eq(r.err, !ok, $sformatf("write error flag for user %h", u));
        do_req(1'b0, sram_addr(word), '0, u, ok ? 3 : 2, r);
        check_eq(r.err, !ok, $sformatf("read error flag for user %h", u));
        check_eq(r.rdata, ok ? d : 32'h0, $sformatf("read data for user %h", u));
        check_eq(sram_en_cnt - en_before, ok ? 2 : 0, "SRAM enable count");
    endtask

    task automatic exec_region_perms();
        start_test();
        @(negedge clk);
        exec_region_lock = 1'b0;
        perm_access(CLP_USER, 10, 1'b1, $random(seed));
        perm_access(LSU_USER, 10, 1'b0, $random(seed));
        perm_access(IFU_USER, 10, 1'b0, $random(seed));
        perm_access(BAD_USER, 10, 1'b0, $random(seed));
        @(negedge clk);
        exec_region_lock = 1'b1;
        perm_access(CLP_USER, 10, 1'b0, $random(seed));
        perm_access(LSU_USER, 10, 1'b1, $random(seed));
        perm_access(IFU_USER, 10, 1'b1, $random(seed));
        perm_access(BAD_USER, 10, 1'b0, $random(seed));
        // Outside the region an unknown user still fails
        perm_access(BAD_USER, 700, 1'b0, $random(seed));
        @(negedge clk);
        exec_region_lock = 1'b0;
        end_test("permissions");
    endtask

    // Cycles until a timeout output rises or the limit runs out
    task automatic wait_timeout(input int which, input int limit, output int n);
        n = 0;
        while (!(which == 1 ? wdt_t1_timeout : wdt_t2_timeout) && n < limit) begin
            @(negedge clk);
            n++;
        end
    endtask

    task automatic watchdog_service();
        int p;
        int n;
        p = 20;
        start_test();
        reg_write(8, 3);
        reg_write(2, p);
        reg_write(3, 0);
        reg_write(0, 1);
        wait_timeout(1, p + 10, n);
        assert (wdt_t1_timeout && n >= p - 2 && n <= p + 6) else begin
            $display("error at %0d ns: timer 1 timeout after %0d cycles, period %0d",
                     $time, n, p);
            errors++;
        end
        reg_write(8, 1);
        check_eq(wdt_t1_timeout, 1'b0, "status after clear");
        reg_write(1, 1);
        wait_timeout(1, p + 10, n);
        assert (wdt_t1_timeout && n >= p - 2 && n <= p + 6) else begin
            $display("error at %0d ns: timeout after restart took %0d cycles", $time, n);
            errors++;
        end
        reg_write(0, 0);
        reg_write(8, 3);
        end_test("watchdog");
    endtask

    task automatic wdt_cascade();
        int p1;
        int p2;
        int n;
        p1 = 10;
        p2 = 15;
        start_test();
        reg_write(6, p2);
        reg_write(7, 0);
        reg_write(2, p1);
        reg_write(0, 1);
        wait_timeout(2, p1 + p2 + 12, n);
        check_eq(wdt_t2_timeout, 1'b1, "timer 2 cascade timeout");
        check_eq(wdt_t1_timeout, 1'b1, "timer 1 status during cascade");
        reg_write(0, 0);
        reg_write(8, 3);
        // Nothing may fire with both timers off
        n = 0;
        repeat (200) begin
            @(negedge clk);
            if (wdt_t1_timeout || wdt_t2_timeout) begin
                n++;
            end
        end
        check_eq(n, 0, "timeout cycles with timers disabled");
        end_test("cascade");
    endtask

    task automatic back_pressure();
        mci_pkg::mci_req_t  reqs [8];
        logic [31:0]        exp_data [8];
        int sent;
        int got;
        int cyc;
        logic outstanding;
        logic acc;
        start_test();
        for (int i = 0; i < 4; i++) begin
            reqs[i] = '{write: 1'b1, addr: sram_addr(600 + i), wdata: $random(seed),
                        user: CLP_USER};
            exp_data[i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            reqs[i + 4] = '{write: 1'b0, addr: sram_addr(600 + i), wdata: '0,
                            user: LSU_USER};
            exp_data[i + 4] = reqs[i].wdata;
        end
        sent = 0;
        got = 0;
        cyc = 0;
        outstanding = 1'b0;
        acc = 1'b0;
        while (got < 8 && cyc < CYC_BACK) begin
            @(negedge clk);
            cyc++;
            if (acc) begin
                sent++;
                outstanding = 1'b1;
                acc = 1'b0;
            end
            assert (!(outstanding && req_ready)) else begin
                $display("error at %0d ns: ready high with a request outstanding", $time);
                errors++;
            end
            if (resp_valid) begin
                check_eq(outstanding, 1'b1, "response without a request");
                check_eq(resp.rdata, exp_data[got], $sformatf("response %0d data", got));
                check_eq(resp.err, 1'b0, "back-to-back error flag");
                got++;
                outstanding = 1'b0;
            end
            if (sent < 8) begin
                req = reqs[sent];
                req_valid = 1'b1;
                acc = req_ready;
            end else begin
                req_valid = 1'b0;
            end
        end
        req_valid = 1'b0;
        check_eq(got, 8, "response count");
        repeat (10) begin
            @(negedge clk);
            check_eq(resp_valid, 1'b0, "extra response");
        end
        end_test("backpressure");
    endtask

    initial begin
        #(CYC_TOTAL * 2 * 20);
        $display("simulation stopped by the watchdog, tests did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        seed = 32'he5456487;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        rst_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        exec_region_lock = 1'b0;
        sram_rdata = '0;
        sram_en_cnt = 0;
        // Fill depends on every address bit
        for (int i = 0; i < `MCI_SRAM_WORDS; i++) begin
            sram_mem[i] = {16'(i) ^ 16'ha5c3, ~16'(i)};
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_eq(req_ready, 1'b1, "ready after reset");
        check_eq(resp_valid, 1'b0, "response after reset");
        check_eq(sram_req.cs, 1'b0, "SRAM enable after reset");
        check_eq({wdt_t2_timeout, wdt_t1_timeout}, 2'b00, "timeouts after reset");
        register_access();
        sram_user_access();
        exec_region_perms();
        watchdog_service();
        wdt_cascade();
        back_pressure();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+include
verilog/mci_pkg.sv
verilog/mci_bus_sub.sv
verilog/mci_sram_ctrl.sv
verilog/mci_reg_bank.sv
verilog/mci_wdt.sv
verilog/mci_top.sv
tb/tb_mci_top.sv

// File: Bender.yml
package:
  name: mci

export_include_dirs:
  - include

sources:
  - files:
      - verilog/mci_pkg.sv
      - verilog/mci_bus_sub.sv
      - verilog/mci_sram_ctrl.sv
      - verilog/mci_reg_bank.sv
      - verilog/mci_wdt.sv
      - verilog/mci_top.sv
  - target: test
    files:
      - tb/tb_mci_top.sv
